// File: hdl/usbDpll.sv
`include "usbRx_macros.svh"

module usbDpll (
    input  logic clk48,
    input  logic rstN,
    input  logic rxActive,
    input  logic lineEdge,
    output logic bitStrobe
);

    // the strobe fires on the last phase of the count
    localparam usbLinePkg::bitPhase_t StrobePhase =
        usbLinePkg::bitPhase_t'(`USB_RX_OVERSAMPLE - 1);
    // an edge loads this phase so the strobe lands two cycles later at mid-bit
    localparam usbLinePkg::bitPhase_t EdgePhase =
        usbLinePkg::bitPhase_t'(`USB_RX_OVERSAMPLE - 2);

    usbLinePkg::bitPhase_t phase;        // free-running position inside the bit

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else if (rxActive) begin     // phase is frozen while the receiver is off
            if (lineEdge) begin
                phase <= EdgePhase;      // re-centre on every transition to follow drift
            end else if (phase == StrobePhase) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    assign bitStrobe = rxActive && (phase == StrobePhase);

endmodule

// File: hdl/usbLinePkg.sv
package usbLinePkg;

    // encoding is the pad pair {dp, dn} so the synchronizer maps it without logic
    typedef enum logic [1:0] {
        lineSe0 = 2'b00,  // both pads low which is an EOP or a bus reset
        lineK   = 2'b01,  // dn high on a full-speed link
        lineJ   = 2'b10,  // dp high and also the idle level
        lineSe1 = 2'b11   // illegal state that aborts a packet
    } lineState_t;

    typedef logic [1:0] bitPhase_t;  // position of clk48 inside one bit period

endpackage

// File: hdl/usbLineSync.sv
module usbLineSync (
    input  logic                   clk48,
    input  logic                   rstN,
    input  logic                   usbDp,
    input  logic                   usbDn,
    output usbLinePkg::lineState_t lineState,
    output logic                   lineEdge
);

    logic [1:0] padMeta;                  // first stage that may go metastable
    logic [1:0] padSync;                  // second stage which is safe to decode
    usbLinePkg::lineState_t prevState;    // state one cycle back for edge detection

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            padMeta   <= 2'b10;           // pads start at idle J
            padSync   <= 2'b10;
            prevState <= usbLinePkg::lineJ;
        end else begin
            padMeta   <= {usbDp, usbDn};
            padSync   <= padMeta;
            prevState <= lineState;
        end
    end

    assign lineState = usbLinePkg::lineState_t'(padSync);  // enum values match the pad pair

    // only J to K and K to J count since SE0 steps do not carry bit timing
    assign lineEdge = ((lineState == usbLinePkg::lineJ) && (prevState == usbLinePkg::lineK)) ||
                      ((lineState == usbLinePkg::lineK) && (prevState == usbLinePkg::lineJ));

endmodule

// File: hdl/usbRxByteFifo.sv
`include "usbRx_macros.svh"

module usbRxByteFifo (
    input  logic              clk48,
    input  logic              rstN,
    input  logic              bytePush,
    input  logic              byteLast,
    input  logic              byteKeep,
    input  usbRxPkg::rxByte_t byteData,
    input  logic              rxAcceptNewData,
    output usbRxPkg::rxByte_t rxData,
    output logic              rxDataValid,
    output logic              rxIsLastByte,
    output logic              keepPacket
);

    localparam int Depth = `USB_RX_FIFO_DEPTH;
    localparam int IdxW  = $clog2(Depth);

    usbRxPkg::rxByte_t dataMem [Depth];
    logic [1:0]        flagMem [Depth];  // last flag on top and keep flag below
    usbRxPkg::fifoPtr_t wrPtr;
    usbRxPkg::fifoPtr_t rdPtr;
    logic              full;
    logic              pop;
    logic              doWrite;
    logic              overflow;         // some byte of the current packet was lost

    assign full    = (wrPtr[IdxW] != rdPtr[IdxW]) && (wrPtr[IdxW-1:0] == rdPtr[IdxW-1:0]);
    assign pop     = rxDataValid && rxAcceptNewData;
    assign doWrite = bytePush && (!full || pop);  // a read in the same cycle frees a slot

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            overflow <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (bytePush && !doWrite) begin
                overflow <= 1'b1;                  // stays set until a last byte goes in
            end else if (doWrite && byteLast) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (doWrite) begin
            dataMem[wrPtr[IdxW-1:0]] <= byteData;
            flagMem[wrPtr[IdxW-1:0]] <= {byteLast, byteKeep && !overflow};
        end
    end

    assign rxDataValid  = (wrPtr != rdPtr);
    assign rxData       = dataMem[rdPtr[IdxW-1:0]];
    assign rxIsLastByte = flagMem[rdPtr[IdxW-1:0]][1];
    assign keepPacket   = flagMem[rdPtr[IdxW-1:0]][0];

endmodule

// File: hdl/usbRxCrc.sv
`include "usbRx_macros.svh"

module usbRxCrc (
    input  logic               clk48,
    input  logic               rstN,
    input  logic               crcBit,
    input  logic               crcShift,
    input  logic               crcClear,
    input  usbRxPkg::crcKind_t crcKind,
    output logic               crcOk
);

    localparam logic [4:0]  Poly5  = 5'h05;     // x^5 + x^2 + 1
    localparam logic [15:0] Poly16 = 16'h8005;  // x^16 + x^15 + x^2 + 1

    logic [4:0]  crc5Reg;
    logic [15:0] crc16Reg;
    logic        fb5;
    logic        fb16;

    assign fb5  = crcBit ^ crc5Reg[4];    // incoming bit meets the top of the register
    assign fb16 = crcBit ^ crc16Reg[15];

    // both registers run on every bit and the packet kind picks which one counts
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            crc5Reg  <= '1;
            crc16Reg <= '1;
        end else if (crcClear) begin
            crc5Reg  <= '1;                   // preset to all ones at each new SYNC
            crc16Reg <= '1;
        end else if (crcShift) begin
            crc5Reg  <= {crc5Reg[3:0], 1'b0} ^ (fb5 ? Poly5 : 5'h00);
            crc16Reg <= {crc16Reg[14:0], 1'b0} ^ (fb16 ? Poly16 : 16'h0000);
        end
    end

    always_comb begin
        case (crcKind)
            usbRxPkg::crcFive:    crcOk = (crc5Reg == `USB_RX_CRC5_RESIDUE);
            usbRxPkg::crcSixteen: crcOk = (crc16Reg == `USB_RX_CRC16_RESIDUE);
            default:              crcOk = 1'b1;  // nothing to check on a handshake
        endcase
    end

endmodule

// File: hdl/usbRxCtrlRegs.sv
`include "usbRx_macros.svh"

module usbRxCtrlRegs (
    input  logic                   clk48,
    input  logic                   rstN,
    input  logic                   rxEnable,
    input  logic                   ackUsbRst,
    input  usbLinePkg::lineState_t lineState,
    output logic                   rxActive,
    output logic                   usbResetDetect
);

    localparam int Limit = `USB_RX_RESET_SE0_CYCLES;

    logic [$clog2(Limit):0] se0Count;  // saturating length of the current SE0 run
    logic                   isSe0;

    assign isSe0 = (lineState == usbLinePkg::lineSe0);

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            rxActive       <= 1'b0;
            usbResetDetect <= 1'b0;
            se0Count       <= '0;
        end else begin
            rxActive <= rxEnable && !usbResetDetect;  // receiver rests while a reset is pending
            if (!isSe0) begin
                se0Count <= '0;
            end else if (se0Count != Limit[$clog2(Limit):0]) begin
                se0Count <= se0Count + 1'b1;
            end
            // the latch sets once per SE0 run so an ack during a long reset sticks
            if (isSe0 && (se0Count == Limit[$clog2(Limit):0] - 1'b1)) begin
                usbResetDetect <= 1'b1;
            end else if (ackUsbRst) begin
                usbResetDetect <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/usbRxDecoder.sv
module usbRxDecoder (
    input  logic                   clk48,
    input  logic                   rstN,
    input  logic                   rxActive,
    input  logic                   bitStrobe,
    input  usbLinePkg::lineState_t lineState,
    input  logic                   crcOk,
    output logic                   crcBit,
    output logic                   crcShift,
    output logic                   crcClear,
    output usbRxPkg::crcKind_t     crcKind,
    output usbRxPkg::rxByte_t      byteData,
    output logic                   bytePush,
    output logic                   byteLast,
    output logic                   byteKeep
);

    usbRxPkg::rxState_t     state;
    usbLinePkg::lineState_t lastLevel;  // J or K sampled at the previous strobe
    logic [2:0]             onesCount;  // run of decoded ones for unstuffing
    logic [2:0]             bitCount;   // position inside the byte being assembled
    usbRxPkg::rxByte_t      shiftReg;   // bits arrive LSB first and shift in from the top
    usbRxPkg::rxByte_t      heldByte;   // completed byte kept back until we know if it is last
    logic                   heldValid;
    logic                   stuffErr;   // a seventh one showed up somewhere in the packet
    logic                   pidBad;     // PID check nibble did not match
    logic                   aligned;    // SE0 arrived on a byte boundary
    logic                   isJk;
    logic                   nrziBit;
    logic                   stuffBit;
    logic                   dataBit;
    usbRxPkg::rxByte_t      newByte;
    usbRxPkg::pidCode_t     pidLow;

    assign isJk     = (lineState == usbLinePkg::lineJ) || (lineState == usbLinePkg::lineK);
    assign nrziBit  = (lineState == lastLevel);  // no change on the line decodes as 1
    assign stuffBit = (onesCount == 3'd6);       // bit after six ones is the stuffed zero
    assign dataBit  = rxActive && bitStrobe && isJk && !stuffBit &&
                      ((state == usbRxPkg::stPid) || (state == usbRxPkg::stPayload));
    assign newByte  = {nrziBit, shiftReg[7:1]};  // byte as it looks with the current bit in
    assign pidLow   = newByte[3:0];

    assign crcBit   = nrziBit;
    assign crcShift = dataBit && (state == usbRxPkg::stPayload);  // the PID is not covered

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            state     <= usbRxPkg::stIdle;
            lastLevel <= usbLinePkg::lineJ;
            onesCount <= '0;
            bitCount  <= '0;
            heldValid <= 1'b0;
            stuffErr  <= 1'b0;
            pidBad    <= 1'b0;
            aligned   <= 1'b0;
            crcClear  <= 1'b0;
            crcKind   <= usbRxPkg::crcNone;
            bytePush  <= 1'b0;
            byteLast  <= 1'b0;
            byteKeep  <= 1'b0;
        end else begin
            bytePush <= 1'b0;                    // both are single-cycle pulses
            crcClear <= 1'b0;
            if (!rxActive) begin
                state     <= usbRxPkg::stIdle;   // drop whatever was in flight
                heldValid <= 1'b0;
            end else if (bitStrobe) begin
                if (isJk) begin
                    lastLevel <= lineState;
                end
                case (state)
                    usbRxPkg::stIdle: begin
                        if (lineState == usbLinePkg::lineK) begin  // first K opens SYNC
                            state     <= usbRxPkg::stSync;
                            crcClear  <= 1'b1;
                            crcKind   <= usbRxPkg::crcNone;
                            stuffErr  <= 1'b0;
                            pidBad    <= 1'b0;
                            heldValid <= 1'b0;
                            bitCount  <= '0;
                        end
                    end
                    usbRxPkg::stSync: begin
                        if (!isJk) begin
                            state <= usbRxPkg::stIdle;
                        end else if (nrziBit) begin  // the closing KK of SYNC
                            state     <= usbRxPkg::stPid;
                            onesCount <= 3'd1;       // that one already counts for stuffing
                        end
                    end
                    usbRxPkg::stPid, usbRxPkg::stPayload: begin
                        if (lineState == usbLinePkg::lineSe0) begin
                            state   <= usbRxPkg::stEop;
                            aligned <= (bitCount == 3'd0);
                        end else if (!isJk) begin
                            state <= usbRxPkg::stIdle;  // SE1 kills the packet
                        end else if (stuffBit) begin
                            onesCount <= '0;            // stuffed zero is dropped
                            if (nrziBit) begin
                                stuffErr <= 1'b1;
                            end
                        end else begin
                            onesCount <= nrziBit ? onesCount + 3'd1 : 3'd0;
                            shiftReg  <= newByte;
                            bitCount  <= bitCount + 3'd1;
                            if (bitCount == 3'd7) begin
                                heldByte  <= newByte;
                                heldValid <= 1'b1;
                                if (state == usbRxPkg::stPid) begin
                                    state  <= usbRxPkg::stPayload;
                                    pidBad <= (newByte[7:4] != ~pidLow);
                                    case (pidLow[1:0])   // low bits give the PID group
                                        2'b01:   crcKind <= usbRxPkg::crcFive;
                                        2'b11:   crcKind <= usbRxPkg::crcSixteen;
                                        default: crcKind <= usbRxPkg::crcNone;
                                    endcase
                                end else if (heldValid) begin  // older byte is not the last one
                                    byteData <= heldByte;
                                    bytePush <= 1'b1;
                                    byteLast <= 1'b0;
                                    byteKeep <= 1'b0;
                                end
                            end
                        end
                    end
                    usbRxPkg::stEop: begin
                        if (lineState == usbLinePkg::lineJ) begin
                            state     <= usbRxPkg::stIdle;
                            heldValid <= 1'b0;
                            if (heldValid) begin         // a packet cut inside its PID is silent
                                byteData <= heldByte;
                                bytePush <= 1'b1;
                                byteLast <= 1'b1;
                                byteKeep <= !stuffErr && !pidBad && aligned && crcOk;
                            end
                        end else if (lineState != usbLinePkg::lineSe0) begin
                            state <= usbRxPkg::stIdle;
                        end
                    end
                    default: state <= usbRxPkg::stIdle;
                endcase
            end
        end
    end

endmodule

// File: hdl/usbRxPkg.sv
`include "usbRx_macros.svh"

package usbRxPkg;

    typedef enum logic [2:0] {
        stIdle,     // line idle and waiting for the first K of SYNC
        stSync,     // inside the KJKJKJKK pattern
        stPid,      // first byte after SYNC
        stPayload,  // data and CRC bytes
        stEop       // SE0 seen and waiting for the closing J
    } rxState_t;

    typedef logic [7:0] rxByte_t;   // one decoded byte
    typedef logic [3:0] pidCode_t;  // lower PID nibble that names the packet type

    typedef enum logic [1:0] {
        crcNone,    // handshakes carry no CRC
        crcFive,    // tokens
        crcSixteen  // DATA0 and DATA1
    } crcKind_t;

    // one extra bit tells a full buffer from an empty one
    typedef logic [$clog2(`USB_RX_FIFO_DEPTH):0] fifoPtr_t;

endpackage

// File: hdl/usbRxTop.sv
module usbRxTop (
    input  logic              clk48,
    input  logic              rstN,
    input  logic              usbDp,
    input  logic              usbDn,
    input  logic              rxEnable,
    input  logic              ackUsbRst,
    input  logic              rxAcceptNewData,  // backend takes the byte shown on rxData
    output logic              usbResetDetect,
    output usbRxPkg::rxByte_t rxData,
    output logic              rxDataValid,
    output logic              rxIsLastByte,     // valid only together with rxDataValid
    output logic              keepPacket        // packet verdict carried by the last byte
);

    usbLinePkg::lineState_t lineState;
    logic                   lineEdge;
    logic                   bitStrobe;
    logic                   rxActive;
    logic                   crcBit;
    logic                   crcShift;
    logic                   crcClear;
    logic                   crcOk;
    usbRxPkg::crcKind_t     crcKind;
    usbRxPkg::rxByte_t      byteData;
    logic                   bytePush;
    logic                   byteLast;
    logic                   byteKeep;

    usbLineSync lineSync_i (
        .clk48, .rstN, .usbDp, .usbDn, .lineState, .lineEdge
    );

    usbDpll dpll_i (
        .clk48, .rstN, .rxActive, .lineEdge, .bitStrobe
    );

    usbRxDecoder decoder_i (
        .clk48, .rstN, .rxActive, .bitStrobe, .lineState, .crcOk,
        .crcBit, .crcShift, .crcClear, .crcKind,
        .byteData, .bytePush, .byteLast, .byteKeep
    );

    usbRxCrc crc_i (
        .clk48, .rstN, .crcBit, .crcShift, .crcClear, .crcKind, .crcOk
    );

    usbRxByteFifo byteFifo_i (
        .clk48, .rstN, .bytePush, .byteLast, .byteKeep, .byteData, .rxAcceptNewData,
        .rxData, .rxDataValid, .rxIsLastByte, .keepPacket
    );

    usbRxCtrlRegs ctrlRegs_i (
        .clk48, .rstN, .rxEnable, .ackUsbRst, .lineState, .rxActive, .usbResetDetect
    );

endmodule

// File: hdl/usbRx_macros.svh
`ifndef USB_RX_MACROS_SVH
`define USB_RX_MACROS_SVH

`define USB_RX_OVERSAMPLE 4          // clk48 cycles in one 12 Mbit/s bit
`define USB_RX_RESET_SE0_CYCLES 120  // 2.5 us of SE0 marks a bus reset
`define USB_RX_FIFO_DEPTH 4          // entries in the byte buffer toward the backend

// remainders left in the LFSRs after a packet and its inverted CRC went through
`define USB_RX_CRC5_RESIDUE 5'b01100
`define USB_RX_CRC16_RESIDUE 16'h800D

`endif

// File: usbRxTop.f
+incdir+hdl
hdl/usbLinePkg.sv
hdl/usbRxPkg.sv
hdl/usbLineSync.sv
hdl/usbDpll.sv
hdl/usbRxDecoder.sv
hdl/usbRxCrc.sv
hdl/usbRxByteFifo.sv
hdl/usbRxCtrlRegs.sv
hdl/usbRxTop.sv
verif/usbRxTb.sv

// File: verif/usbRxTb.sv
`include "usbRx_macros.svh"

module usbRxTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BitCycles = `USB_RX_OVERSAMPLE;
    localparam int GridSlot = 3;                   // cycle slot where every SYNC starts
    localparam int NumPackets = 11;
    localparam int NumBytes = 53;
    localparam int OverheadBits = 16;              // SYNC, EOP and idle gap of one packet
    localparam int PacketBits = NumPackets * OverheadBits + (NumBytes * 8 * 7) / 6;
    localparam int ResetTestCycles = 260;          // both SE0 runs with their checks
    localparam int TimeoutCycles = 2 * (PacketBits * BitCycles + ResetTestCycles);
    localparam int unsigned RandSeed = 32'h270c_f688;
    localparam logic [1:0] PadJ = 2'b10;           // {dp, dn}
    localparam logic [1:0] PadSe0 = 2'b00;

    logic              clk48;
    logic              rstN;
    logic              usbDp;
    logic              usbDn;
    logic              rxEnable;
    logic              ackUsbRst;
    logic              rxAcceptNewData;
    logic              usbResetDetect;
    usbRxPkg::rxByte_t rxData;
    logic              rxDataValid;
    logic              rxIsLastByte;
    logic              keepPacket;

    logic [7:0]  txBytes[$];      // PID, payload and CRC bytes of the packet on the line
    logic [7:0]  savedPacket[$];
    logic [7:0]  expData[$];      // bytes the backend should still receive
    logic        expLast[$];
    logic        expKeep[$];
    logic [7:0]  payloadBuf[16];
    logic [1:0]  lineLevel;       // current J or K of the NRZI encoder
    int          onesRun;         // ones sent in a row for bit stuffing
    int          cycleCount;

    usbRxTop dut_i (
        .clk48, .rstN, .usbDp, .usbDn, .rxEnable, .ackUsbRst, .rxAcceptNewData,
        .usbResetDetect, .rxData, .rxDataValid, .rxIsLastByte, .keepPacket
    );

    always #5 clk48 = ~clk48;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            reportFailure($sformatf("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    always @(posedge clk48) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            reportFailure($sformatf("timeout: tests still running after %0d cycles", cycleCount));
        end
    end

    // negedge sampling sees the byte that the next rising edge pops from the buffer
    always @(negedge clk48) begin : collectBytes
        logic [7:0] wantData;
        logic       wantLast;
        logic       wantKeep;
        if (rstN && rxDataValid && rxAcceptNewData) begin
            if (expData.size() == 0) begin
                reportFailure($sformatf("byte 0x%0h delivered at %0t ns with none expected",
                                        rxData, $time));
            end else begin
                wantData = expData.pop_front();
                wantLast = expLast.pop_front();
                wantKeep = expKeep.pop_front();
                checkValue("rxData", {8'h00, rxData}, {8'h00, wantData});
                checkValue("rxIsLastByte", {15'b0, rxIsLastByte}, {15'b0, wantLast});
                if (wantLast) begin                  // verdict only counts on the last byte
                    checkValue("keepPacket", {15'b0, keepPacket}, {15'b0, wantKeep});
                end
            end
        end
    end

    function automatic logic [7:0] randomByte();
        int unsigned r;
        r = $urandom;
        return r[7:0];
    endfunction

    // reflected form of x^16 + x^15 + x^2 + 1, sent inverted and low byte first
    function automatic logic [15:0] crc16Of(input int first, input int count);
        logic [15:0] c;
        logic        fb;
        c = 16'hFFFF;
        for (int n = first; n < first + count; n++) begin
            for (int k = 0; k < 8; k++) begin
                fb = txBytes[n][k] ^ c[0];
                c = c >> 1;
                if (fb) begin
                    c = c ^ 16'hA001;
                end
            end
        end
        return ~c;
    endfunction

    // reflected form of x^5 + x^2 + 1 over the 11 token bits
    function automatic logic [4:0] crc5Of(input logic [10:0] field);
        logic [4:0] c;
        logic       fb;
        c = 5'h1F;
        for (int k = 0; k < 11; k++) begin
            fb = field[k] ^ c[0];
            c = c >> 1;
            if (fb) begin
                c = c ^ 5'h14;
            end
        end
        return ~c;
    endfunction

    task automatic holdLine(input logic [1:0] pads, input int cycles);
        {usbDp, usbDn} = pads;
        repeat (cycles) begin
            @(posedge clk48);
            #1;
        end
    endtask

    task automatic sendBit(input logic value);
        if (!value) begin
            lineLevel = ~lineLevel;                  // a zero toggles between J and K
        end
        holdLine(lineLevel, BitCycles);
        onesRun = value ? onesRun + 1 : 0;
        if (onesRun == 6) begin                      // stuffed zero after six ones
            lineLevel = ~lineLevel;
            holdLine(lineLevel, BitCycles);
            onesRun = 0;
        end
    endtask

    task automatic sendByte(input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            sendBit(value[i]);                       // LSB goes out first
        end
    endtask

    task automatic sendPacket();
        while ((cycleCount % BitCycles) != GridSlot) begin  // same bit grid for every packet
            @(posedge clk48);
            #1;
        end
        lineLevel = PadJ;
        onesRun = 0;
        sendByte(8'h80);                             // seven zeros and a one give KJKJKJKK
        foreach (txBytes[i]) begin
            sendByte(txBytes[i]);
        end
        holdLine(PadSe0, 2 * BitCycles);
        holdLine(PadJ, BitCycles);
    endtask

    task automatic buildDataPacket(input logic [7:0] pid, input int count);
        logic [15:0] crc;
        txBytes.delete();
        txBytes.push_back(pid);
        for (int i = 0; i < count; i++) begin
            txBytes.push_back(payloadBuf[i]);
        end
        crc = crc16Of(1, count);
        txBytes.push_back(crc[7:0]);
        txBytes.push_back(crc[15:8]);
    endtask

    task automatic buildToken(input logic [7:0] pid, input logic [6:0] addr, input logic [3:0] endp);
        logic [10:0] field;
        logic [15:0] word;
        field = {endp, addr};
        word = {crc5Of(field), field};               // CRC5 fills the top five bits
        txBytes.delete();
        txBytes.push_back(pid);
        txBytes.push_back(word[7:0]);
        txBytes.push_back(word[15:8]);
    endtask

    task automatic buildHandshake(input logic [7:0] pid);
        txBytes.delete();
        txBytes.push_back(pid);
    endtask

    task automatic expectPacket(input logic keep, input int count);
        for (int i = 0; i < count; i++) begin
            expData.push_back(txBytes[i]);
            expLast.push_back(i == txBytes.size() - 1);
            expKeep.push_back(keep);
        end
    endtask

    task automatic waitDrained();
        while (expData.size() != 0) begin            // the cycle counter bounds this wait
            @(posedge clk48);
            #1;
        end
        holdLine(PadJ, 8);
    endtask

    task automatic testGoodData();
        for (int i = 0; i < 6; i++) begin
            payloadBuf[i] = randomByte();
        end
        buildDataPacket(8'hC3, 6);                   // DATA0
        savedPacket = txBytes;
        expectPacket(1'b1, txBytes.size());
        sendPacket();
        waitDrained();
    endtask

    task automatic testCorruptPackets();
        txBytes = savedPacket;
        txBytes[3] = txBytes[3] ^ 8'h10;             // CRC still covers the original payload
        expectPacket(1'b0, txBytes.size());
        sendPacket();
        waitDrained();
        for (int i = 0; i < 3; i++) begin
            payloadBuf[i] = randomByte();
        end
        buildDataPacket(8'h5B, 3);                   // DATA1 code with a broken check nibble
        expectPacket(1'b0, txBytes.size());
        sendPacket();
        waitDrained();
    endtask

    task automatic testTokenHandshake();
        buildToken(8'hE1, 7'h15, 4'h3);              // OUT token
        expectPacket(1'b1, txBytes.size());
        sendPacket();
        waitDrained();
        buildHandshake(8'hD2);                       // ACK
        expectPacket(1'b1, 1);
        sendPacket();
        waitDrained();
        payloadBuf[0] = 8'hFF;                       // long runs of ones force stuffed zeros
        payloadBuf[1] = 8'hFF;
        payloadBuf[2] = 8'h7F;
        payloadBuf[3] = 8'hFE;
        buildDataPacket(8'h4B, 4);
        expectPacket(1'b1, txBytes.size());
        sendPacket();
        waitDrained();
    endtask

    task automatic testBackPressure();
        rxAcceptNewData = 1'b0;
        payloadBuf[0] = randomByte();
        buildDataPacket(8'hC3, 1);                   // four bytes fill the buffer exactly
        expectPacket(1'b1, txBytes.size());
        sendPacket();
        holdLine(PadJ, 12);
        @(negedge clk48);
        checkValue("rxDataValid", {15'b0, rxDataValid}, 16'd1);
        @(posedge clk48);
        #1;
        rxAcceptNewData = 1'b1;
        waitDrained();
        rxAcceptNewData = 1'b0;
        for (int i = 0; i < 4; i++) begin
            payloadBuf[i] = randomByte();
        end
        buildDataPacket(8'h4B, 4);                   // seven bytes and only four slots
        expectPacket(1'b0, `USB_RX_FIFO_DEPTH);
        sendPacket();
        holdLine(PadJ, 12);
        rxAcceptNewData = 1'b1;
        waitDrained();
        buildHandshake(8'hD2);                       // lost bytes spoil this verdict
        expectPacket(1'b0, 1);
        sendPacket();
        waitDrained();
        expectPacket(1'b1, 1);                       // overflow is gone for the next one
        sendPacket();
        waitDrained();
    endtask

    task automatic testBusReset();
        holdLine(PadSe0, 130);
        holdLine(PadJ, 4);
        @(negedge clk48);
        checkValue("usbResetDetect", {15'b0, usbResetDetect}, 16'd1);
        @(posedge clk48);
        #1;
        ackUsbRst = 1'b1;
        @(posedge clk48);
        #1;
        ackUsbRst = 1'b0;
        @(negedge clk48);
        checkValue("usbResetDetect", {15'b0, usbResetDetect}, 16'd0);
        @(posedge clk48);
        #1;
        holdLine(PadSe0, 60);                        // too short for a bus reset
        holdLine(PadJ, 4);
        @(negedge clk48);
        checkValue("usbResetDetect", {15'b0, usbResetDetect}, 16'd0);
        @(posedge clk48);
        #1;
        rxEnable = 1'b0;
        holdLine(PadJ, 4);
        payloadBuf[0] = randomByte();
        payloadBuf[1] = randomByte();
        buildDataPacket(8'hC3, 2);                   // nothing expected while disabled
        sendPacket();
        holdLine(PadJ, 12);
        @(negedge clk48);
        checkValue("rxDataValid", {15'b0, rxDataValid}, 16'd0);
        @(posedge clk48);
        #1;
        rxEnable = 1'b1;
        holdLine(PadJ, 8);
    endtask

    initial begin
        void'($urandom(RandSeed));
        clk48 = 1'b0;
        rstN = 1'b0;
        usbDp = 1'b1;                                // idle J on the pads
        usbDn = 1'b0;
        rxEnable = 1'b1;
        ackUsbRst = 1'b0;
        rxAcceptNewData = 1'b1;
        cycleCount = 0;
        repeat (3) @(posedge clk48);
        #1;
        rstN = 1'b1;
        holdLine(PadJ, 8);
        testGoodData();
        testCorruptPackets();
        testTokenHandshake();
        testBackPressure();
        testBusReset();
        if (expData.size() != 0) begin
            reportFailure($sformatf("%0d expected bytes never arrived", expData.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
